//--- ulaPkg.sv
// Processing unit package with widths, data types, ALU opcodes, instruction fields and states
package ulaPkg;
	localparam int WordBits = 16;                   // Data path width
	localparam int RegCount = 8;                    // Register file size
	localparam int ProgDepth = 16;                  // Program store words
	localparam int RegAddrBits = $clog2(RegCount);  // 3 bit register index
	localparam int PcBits = $clog2(ProgDepth);      // 4 bit program address

	typedef logic [WordBits-1:0] wordT;             // Signed data word, two's complement
	typedef logic [RegAddrBits-1:0] regAddrT;
	typedef logic [4:0] opCodeT;                    // ALU control code
	typedef logic [PcBits-1:0] pcT;
	typedef logic [WordBits-1:0] instrT;
	typedef logic [3:0] flagsT;                     // Zero, carry, sign, overflow

	// Flag positions inside flagsT
	localparam int FlagZ = 3;
	localparam int FlagC = 2;
	localparam int FlagS = 1;
	localparam int FlagO = 0;

	localparam flagsT ArithMask = 4'b1111;          // Arithmetic touches every flag
	localparam flagsT ShiftMask = 4'b1110;          // Z, C and S
	localparam flagsT LogicMask = 4'b1010;          // Z and S only
	localparam flagsT NoFlags = 4'b0000;            // Constants, copies, unused codes

	// Instruction layout, fields counted from their lsb
	localparam int HaltBit = 15;
	localparam int OpLsb = 10;
	localparam int DstLsb = 7;
	localparam int SrcALsb = 4;
	localparam int SrcBLsb = 1;

	localparam opCodeT OpAdd = 5'b00000;      // A + B
	localparam opCodeT OpAddInc = 5'b00001;   // A + B + 1
	localparam opCodeT OpInc = 5'b00011;      // A + 1
	localparam opCodeT OpSubDec = 5'b00100;   // A - B - 1
	localparam opCodeT OpSub = 5'b00101;      // A - B
	localparam opCodeT OpDec = 5'b00110;      // A - 1
	localparam opCodeT OpShl = 5'b01000;      // Logical shift left
	localparam opCodeT OpSar = 5'b01001;      // Arithmetic shift right
	localparam opCodeT OpZero = 5'b10000;
	localparam opCodeT OpAnd = 5'b10001;
	localparam opCodeT OpNotAAndB = 5'b10010;
	localparam opCodeT OpCopyB = 5'b10011;
	localparam opCodeT OpAAndNotB = 5'b10100;
	localparam opCodeT OpCopyA = 5'b10101;
	localparam opCodeT OpXor = 5'b10110;
	localparam opCodeT OpOr = 5'b10111;
	localparam opCodeT OpNor = 5'b11000;
	localparam opCodeT OpXnor = 5'b11001;
	localparam opCodeT OpNotA = 5'b11010;
	localparam opCodeT OpNotAOrB = 5'b11011;
	localparam opCodeT OpNotB = 5'b11100;
	localparam opCodeT OpAOrNotB = 5'b11101;
	localparam opCodeT OpNand = 5'b11110;
	localparam opCodeT OpOne = 5'b11111;

	typedef enum logic [1:0] {SeqIdle, SeqFetch, SeqExec, SeqWrite} seqStateT;
endpackage

//--- ulaBus.sv
// ALU bus linking register operands, sequencer control code and ALU result and flags
interface ulaBus;
	ulaPkg::wordT opA;         // Operand A from the register file
	ulaPkg::wordT opB;         // Operand B from the register file
	ulaPkg::opCodeT control;   // Opcode of the instruction in flight
	ulaPkg::wordT result;      // Combinational ALU result
	ulaPkg::flagsT flags;      // Registered status flags

	modport regSide (
		output opA,
		output opB
	);

	modport ctlSide (
		output control
	);

	modport aluSide (
		input opA,
		input opB,
		input control,
		output result,
		output flags
	);
endinterface

//--- ula.sv
// ALU computing all 32 control codes with a flag register loaded per operation class
module ula (
	input logic clk,
	input logic rstN,
	ulaBus.aluSide bus,
	input logic flagsWe
);
	localparam int Msb = ulaPkg::WordBits - 1;

	ulaPkg::wordT res;
	ulaPkg::wordT bEff;               // B as used by arithmetic, 1 for inc and dec
	logic [ulaPkg::WordBits:0] wide;  // Bit 16 holds carry or borrow
	logic isSub;
	logic carryBit;
	logic ovfBit;
	ulaPkg::flagsT updMask;
	ulaPkg::flagsT cand;
	ulaPkg::flagsT flagsQ;

	always_comb begin
		res = ulaPkg::wordT'(bus.control);  // Unused codes echo the control code
		bEff = bus.opB;
		wide = '0;
		isSub = 1'b0;
		carryBit = 1'b0;
		updMask = ulaPkg::NoFlags;
		case (bus.control)
			ulaPkg::OpAdd, ulaPkg::OpAddInc, ulaPkg::OpInc: begin
				if (bus.control == ulaPkg::OpInc)
					bEff = ulaPkg::wordT'(1);
				wide = {1'b0, bus.opA} + {1'b0, bEff};
				if (bus.control == ulaPkg::OpAddInc)
					wide = wide + 1'b1;   // Carry in
				updMask = ulaPkg::ArithMask;
			end
			ulaPkg::OpSubDec, ulaPkg::OpSub, ulaPkg::OpDec: begin
				if (bus.control == ulaPkg::OpDec)
					bEff = ulaPkg::wordT'(1);
				wide = {1'b0, bus.opA} - {1'b0, bEff};  // Wraps, so bit 16 is the borrow
				if (bus.control == ulaPkg::OpSubDec)
					wide = wide - 1'b1;
				isSub = 1'b1;
				updMask = ulaPkg::ArithMask;
			end
			ulaPkg::OpShl: begin
				res = bus.opA << 1;
				carryBit = bus.opA[Msb];    // Bit shifted out on the left
				updMask = ulaPkg::ShiftMask;
			end
			ulaPkg::OpSar: begin
				res = ulaPkg::wordT'($signed(bus.opA) >>> 1);  // Sign bit kept
				carryBit = bus.opA[0];
				updMask = ulaPkg::ShiftMask;
			end
			ulaPkg::OpZero: res = '0;
			ulaPkg::OpCopyB: res = bus.opB;
			ulaPkg::OpOne: res = ulaPkg::wordT'(1);
			ulaPkg::OpAnd: res = bus.opA & bus.opB;
			ulaPkg::OpNotAAndB: res = ~bus.opA & bus.opB;
			ulaPkg::OpAAndNotB: res = bus.opA & ~bus.opB;
			ulaPkg::OpCopyA: res = bus.opA;
			ulaPkg::OpXor: res = bus.opA ^ bus.opB;
			ulaPkg::OpOr: res = bus.opA | bus.opB;
			ulaPkg::OpNor: res = ~bus.opA & ~bus.opB;
			ulaPkg::OpXnor: res = ~(bus.opA ^ bus.opB);
			ulaPkg::OpNotA: res = ~bus.opA;
			ulaPkg::OpNotAOrB: res = ~bus.opA | bus.opB;
			ulaPkg::OpNotB: res = ~bus.opB;
			ulaPkg::OpAOrNotB: res = bus.opA | ~bus.opB;
			ulaPkg::OpNand: res = ~bus.opA | ~bus.opB;
			default: ;
		endcase
		// Logic class is every code from 10001 up except copy of B and the constant one
		if (bus.control[4]
				&& !(bus.control inside {ulaPkg::OpZero, ulaPkg::OpCopyB, ulaPkg::OpOne}))
			updMask = ulaPkg::LogicMask;
		if (updMask == ulaPkg::ArithMask) begin
			res = wide[Msb:0];
			carryBit = wide[ulaPkg::WordBits];
		end
		// Signed overflow: result sign departs from A when the operand signs allow it
		if (isSub)
			ovfBit = (bus.opA[Msb] != bEff[Msb]) && (res[Msb] != bus.opA[Msb]);
		else
			ovfBit = (bus.opA[Msb] == bEff[Msb]) && (res[Msb] != bus.opA[Msb]);
		cand[ulaPkg::FlagZ] = (res == '0);
		cand[ulaPkg::FlagC] = carryBit;
		cand[ulaPkg::FlagS] = res[Msb];
		cand[ulaPkg::FlagO] = ovfBit;
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			flagsQ <= '0;
		else if (flagsWe)
			flagsQ <= (cand & updMask) | (flagsQ & ~updMask);  // Untouched flags hold
	end

	assign bus.result = res;
	assign bus.flags = flagsQ;

	// Flags must stay known through every write-back once out of reset
	flagsKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(flagsQ));
endmodule

//--- regFile.sv
// Register file of eight words with two operand read ports, one debug read and one write port
module regFile (
	input logic clk,
	input logic rstN,
	ulaBus.regSide bus,
	input ulaPkg::regAddrT rdAddrA,
	input ulaPkg::regAddrT rdAddrB,
	input logic wrEn,
	input ulaPkg::regAddrT wrAddr,
	input ulaPkg::wordT wrData,
	input ulaPkg::regAddrT dbgAddr,
	output ulaPkg::wordT dbgData
);
	ulaPkg::wordT regs [ulaPkg::RegCount];

	// Preload or write-back, chosen upstream
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			regs <= '{default: '0};          // All registers start at 0
		else if (wrEn)
			regs[wrAddr] <= wrData;
	end

	assign bus.opA = regs[rdAddrA];  // Combinational reads
	assign bus.opB = regs[rdAddrB];
	assign dbgData = regs[dbgAddr];  // Read back for the outside world
endmodule

//--- progMem.sv
// Program store of sixteen instructions, written from outside and read by the program counter
module progMem (
	input logic clk,
	input logic we,
	input ulaPkg::pcT wrAddr,
	input ulaPkg::instrT wrData,
	input ulaPkg::pcT rdAddr,
	output ulaPkg::instrT rdData
);
	ulaPkg::instrT mem [ulaPkg::ProgDepth];

	always_ff @(posedge clk) begin
		if (we)
			mem[wrAddr] <= wrData;   // Loading only while idle
	end

	assign rdData = mem[rdAddr];   // Async read, latched by the sequencer in fetch
endmodule

//--- pcCounter.sv
// Program counter with clear, step and detection of the last program address
module pcCounter (
	input logic clk,
	input logic rstN,
	input logic clear,
	input logic step,
	output ulaPkg::pcT pc,
	output logic atLast
);
	localparam ulaPkg::pcT LastAddr = ulaPkg::pcT'(ulaPkg::ProgDepth - 1);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			pc <= '0;
		else if (clear)
			pc <= '0;             // New run starts at address 0
		else if (step)
			pc <= pc + 1'b1;
	end

	assign atLast = (pc == LastAddr);  // No wrap past the end

	// Sequencer clears only in idle and steps only in write-back
	stepClearExcl: assert property (@(posedge clk) disable iff (!rstN) !(step && clear));
endmodule

//--- seqControl.sv
// Sequencer FSM stepping each instruction through fetch, execute and write-back
module seqControl (
	input logic clk,
	input logic rstN,
	input logic start,
	input ulaPkg::instrT instr,
	input logic atLast,
	output logic pcClear,
	output logic pcStep,
	output logic regWrEn,
	output logic flagsWe,
	output logic busy,
	output logic done,
	output ulaPkg::regAddrT rdAddrA,
	output ulaPkg::regAddrT rdAddrB,
	output ulaPkg::regAddrT wrAddr,
	ulaBus.ctlSide bus
);
	ulaPkg::seqStateT state;
	ulaPkg::seqStateT nextState;
	ulaPkg::instrT instrQ;      // Instruction in flight
	logic stopRun;

	assign stopRun = instrQ[ulaPkg::HaltBit] | atLast;  // Halt bit or end of program

	always_comb begin
		nextState = state;
		case (state)
			ulaPkg::SeqIdle: if (start) nextState = ulaPkg::SeqFetch;  // Start ignored elsewhere
			ulaPkg::SeqFetch: nextState = ulaPkg::SeqExec;
			ulaPkg::SeqExec: nextState = ulaPkg::SeqWrite;
			ulaPkg::SeqWrite: nextState = stopRun ? ulaPkg::SeqIdle : ulaPkg::SeqFetch;
			default: nextState = ulaPkg::SeqIdle;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= ulaPkg::SeqIdle;
			done <= 1'b0;
		end else begin
			state <= nextState;
			done <= (state == ulaPkg::SeqWrite) && stopRun;  // One cycle after last write
		end
	end

	always_ff @(posedge clk) begin
		if (state == ulaPkg::SeqFetch)
			instrQ <= instr;
	end

	// Fields held stable through execute and write-back
	assign rdAddrA = instrQ[ulaPkg::SrcALsb +: ulaPkg::RegAddrBits];
	assign rdAddrB = instrQ[ulaPkg::SrcBLsb +: ulaPkg::RegAddrBits];
	assign wrAddr = instrQ[ulaPkg::DstLsb +: ulaPkg::RegAddrBits];
	assign bus.control = instrQ[ulaPkg::OpLsb +: $bits(ulaPkg::opCodeT)];

	assign pcClear = (state == ulaPkg::SeqIdle) && start;
	assign pcStep = (state == ulaPkg::SeqWrite) && !stopRun;
	assign regWrEn = (state == ulaPkg::SeqWrite);
	assign flagsWe = (state == ulaPkg::SeqWrite);  // Flags and result commit together
	assign busy = (state != ulaPkg::SeqIdle);

	// A run only ends from write-back and leaves the unit idle
	doneAfterWrite: assert property (@(posedge clk) disable iff (!rstN)
		done |-> $past(state) == ulaPkg::SeqWrite && state == ulaPkg::SeqIdle);
endmodule

//--- procUnit.sv
// Multicycle processing unit top level joining sequencer, program store, registers and ALU
module procUnit (
	input logic clk,
	input logic rstN,
	input logic progWe,
	input ulaPkg::pcT progAddr,
	input ulaPkg::instrT progData,
	input logic regWe,
	input ulaPkg::regAddrT regWrAddr,
	input ulaPkg::wordT regWrData,
	input ulaPkg::regAddrT regRdAddr,
	output ulaPkg::wordT regRdData,
	input logic start,
	output logic busy,
	output logic done,
	output ulaPkg::flagsT flags
);
	ulaBus bus ();

	ulaPkg::pcT pc;
	ulaPkg::instrT instr;
	logic atLast;
	logic pcClear;
	logic pcStep;
	logic seqWrEn;
	logic flagsWe;
	ulaPkg::regAddrT rdAddrA;
	ulaPkg::regAddrT rdAddrB;
	ulaPkg::regAddrT seqWrAddr;
	logic wrEn;
	ulaPkg::regAddrT wrAddr;
	ulaPkg::wordT wrData;

	// Write port goes to write-back during a run, to preload when idle
	assign wrEn = busy ? seqWrEn : regWe;
	assign wrAddr = busy ? seqWrAddr : regWrAddr;
	assign wrData = busy ? bus.result : regWrData;
	assign flags = bus.flags;

	ula alu (.clk(clk), .rstN(rstN), .bus(bus.aluSide), .flagsWe(flagsWe));

	regFile regs (
		.clk(clk), .rstN(rstN), .bus(bus.regSide),
		.rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.dbgAddr(regRdAddr), .dbgData(regRdData)
	);

	progMem prog (
		.clk(clk), .we(progWe && !busy), .wrAddr(progAddr), .wrData(progData),
		.rdAddr(pc), .rdData(instr)
	);

	pcCounter pcCnt (
		.clk(clk), .rstN(rstN), .clear(pcClear), .step(pcStep), .pc(pc), .atLast(atLast)
	);

	seqControl seq (
		.clk(clk), .rstN(rstN), .start(start), .instr(instr), .atLast(atLast),
		.pcClear(pcClear), .pcStep(pcStep), .regWrEn(seqWrEn), .flagsWe(flagsWe),
		.busy(busy), .done(done), .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
		.wrAddr(seqWrAddr), .bus(bus.ctlSide)
	);
endmodule

//--- procUnitModel.svh
// Reference model of the ALU result and per-class flag update, used by the testbench
`ifndef PROC_UNIT_MODEL_SVH
`define PROC_UNIT_MODEL_SVH

function automatic ulaPkg::wordT modelResult(input ulaPkg::opCodeT op,
		input ulaPkg::wordT a, input ulaPkg::wordT b);
	case (op)
		ulaPkg::OpAdd: return a + b;
		ulaPkg::OpAddInc: return a + b + 16'd1;
		ulaPkg::OpInc: return a + 16'd1;
		ulaPkg::OpSubDec: return a - b - 16'd1;
		ulaPkg::OpSub: return a - b;
		ulaPkg::OpDec: return a - 16'd1;
		ulaPkg::OpShl: return {a[14:0], 1'b0};
		ulaPkg::OpSar: return {a[15], a[15:1]};   // Sign replicated
		ulaPkg::OpZero: return 16'd0;
		ulaPkg::OpAnd: return a & b;
		ulaPkg::OpNotAAndB: return ~a & b;
		ulaPkg::OpCopyB: return b;
		ulaPkg::OpAAndNotB: return a & ~b;
		ulaPkg::OpCopyA: return a;
		ulaPkg::OpXor: return a ^ b;
		ulaPkg::OpOr: return a | b;
		ulaPkg::OpNor: return ~(a | b);
		ulaPkg::OpXnor: return ~(a ^ b);
		ulaPkg::OpNotA: return ~a;
		ulaPkg::OpNotAOrB: return ~a | b;
		ulaPkg::OpNotB: return ~b;
		ulaPkg::OpAOrNotB: return a | ~b;
		ulaPkg::OpNand: return ~(a & b);
		ulaPkg::OpOne: return 16'd1;
		default: return {11'd0, op};            // Unused codes echo the opcode
	endcase
endfunction

// Flags after one instruction, given the flags before it
function automatic ulaPkg::flagsT modelFlags(input ulaPkg::opCodeT op,
		input ulaPkg::wordT a, input ulaPkg::wordT b, input ulaPkg::flagsT old);
	logic [16:0] w;
	ulaPkg::wordT r;
	ulaPkg::wordT bb;
	r = modelResult(op, a, b);
	bb = (op == ulaPkg::OpInc || op == ulaPkg::OpDec) ? 16'd1 : b;
	case (op)
		ulaPkg::OpAdd, ulaPkg::OpAddInc, ulaPkg::OpInc: begin
			w = {1'b0, a} + {1'b0, bb} + ((op == ulaPkg::OpAddInc) ? 17'd1 : 17'd0);
			return {r == 16'd0, w[16], r[15], (a[15] == bb[15]) && (r[15] != a[15])};
		end
		ulaPkg::OpSubDec, ulaPkg::OpSub, ulaPkg::OpDec: begin
			w = {1'b0, a} - {1'b0, bb} - ((op == ulaPkg::OpSubDec) ? 17'd1 : 17'd0);
			return {r == 16'd0, w[16], r[15], (a[15] != bb[15]) && (r[15] != a[15])};
		end
		ulaPkg::OpShl: return {r == 16'd0, a[15], r[15], old[ulaPkg::FlagO]};
		ulaPkg::OpSar: return {r == 16'd0, a[0], r[15], old[ulaPkg::FlagO]};
		ulaPkg::OpZero, ulaPkg::OpCopyB, ulaPkg::OpOne: return old;
		default: begin
			if (op[4])   // Remaining codes with msb set are logic
				return {r == 16'd0, old[ulaPkg::FlagC], r[15], old[ulaPkg::FlagO]};
			return old;
		end
	endcase
endfunction

`endif

//--- procUnitTb.sv
// Testbench for the processing unit, checking results, flags and run timing by assertions
module procUnitTb;
	localparam int TimeoutCycles = 2000;  // About 170 runs of 9 cycles each, plus margin

	logic clk;
	logic rstN;
	logic progWe;
	ulaPkg::pcT progAddr;
	ulaPkg::instrT progData;
	logic regWe;
	ulaPkg::regAddrT regWrAddr;
	ulaPkg::wordT regWrData;
	ulaPkg::regAddrT regRdAddr;
	ulaPkg::wordT regRdData;
	logic start;
	logic busy;
	logic done;
	ulaPkg::flagsT flags;

	ulaPkg::wordT expRegs [ulaPkg::RegCount];  // Expected register contents
	ulaPkg::flagsT expFlags;                   // Expected flags, carried across runs
	int cycleCount = 0;
	ulaPkg::wordT edgeVals [4] = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000};
	ulaPkg::opCodeT arithOps [6] = '{ulaPkg::OpAdd, ulaPkg::OpAddInc, ulaPkg::OpInc,
		ulaPkg::OpSubDec, ulaPkg::OpSub, ulaPkg::OpDec};
	ulaPkg::opCodeT shiftOps [2] = '{ulaPkg::OpShl, ulaPkg::OpSar};

	`include "procUnitModel.svh"

	procUnit UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles)
			failRun("Timeout: the test did not finish within the cycle limit");
	end

	function automatic ulaPkg::wordT randWord();
		return ulaPkg::wordT'($urandom);
	endfunction

	// Halt, opcode, destination, source A, source B, spare bit
	function automatic ulaPkg::instrT encodeInstr(input logic halt, input ulaPkg::opCodeT op,
			input ulaPkg::regAddrT dst, input ulaPkg::regAddrT srcA, input ulaPkg::regAddrT srcB);
		return {halt, op, dst, srcA, srcB, 1'b0};
	endfunction

	task automatic writeReg(input ulaPkg::regAddrT addr, input ulaPkg::wordT data);
		@(posedge clk);
		regWe <= 1'b1;
		regWrAddr <= addr;
		regWrData <= data;
		expRegs[addr] = data;
	endtask

	task automatic writeProg(input ulaPkg::pcT addr, input ulaPkg::instrT data);
		@(posedge clk);
		progWe <= 1'b1;
		progAddr <= addr;
		progData <= data;
	endtask

	// Pulse start and wait for done; with disturb, start and register writes hit a busy unit
	task automatic runProgram(input int n, input logic disturb);
		int cycles;
		@(posedge clk);
		regWe <= 1'b0;
		progWe <= 1'b0;
		start <= 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (disturb && cycles <= 3 * n) begin  // Sampled next edge, still busy then
				start <= 1'b1;
				regWe <= 1'b1;
				regWrAddr <= ulaPkg::regAddrT'($urandom);
				regWrData <= randWord();
			end else begin
				start <= 1'b0;
				regWe <= 1'b0;
			end
			@(negedge clk);
			assert (done || busy) else
				failRun($sformatf("Fail %0t: busy dropped before done", $time));
		end while (!done);
		assert (cycles == 3 * n + 1) else
			failRun($sformatf("Fail %0t: done after %0d cycles, expected %0d", $time, cycles,
				3 * n + 1));
	endtask

	task automatic checkReg(input ulaPkg::regAddrT addr);
		@(posedge clk);
		regRdAddr <= addr;
		@(negedge clk);
		assert (regRdData == expRegs[addr]) else
			failRun($sformatf("Fail %0t: r%0d reads %h, expected %h", $time, addr, regRdData,
				expRegs[addr]));
	endtask

	task automatic checkFlags(input ulaPkg::opCodeT op);
		assert (flags == expFlags) else
			failRun($sformatf("Fail %0t: op %b flags %b, expected %b", $time, op, flags,
				expFlags));
	endtask

	// One instruction r3 = r1 op r2 with halt set
	task automatic checkOp(input ulaPkg::opCodeT op, input ulaPkg::wordT a, input ulaPkg::wordT b);
		writeReg(3'd1, a);
		writeReg(3'd2, b);
		writeProg(4'd0, encodeInstr(1'b1, op, 3'd3, 3'd1, 3'd2));
		runProgram(1, 1'b0);
		expRegs[3] = modelResult(op, a, b);
		expFlags = modelFlags(op, a, b, expFlags);
		checkFlags(op);
		checkReg(3'd3);
	endtask

	// Five chained instructions, disturbed by start and register writes while busy
	task automatic checkProgram();
		ulaPkg::instrT prog [5];
		ulaPkg::wordT a;
		ulaPkg::wordT b;
		prog[0] = encodeInstr(1'b0, ulaPkg::OpAdd, 3'd1, 3'd0, 3'd2);
		prog[1] = encodeInstr(1'b0, ulaPkg::OpXor, 3'd3, 3'd1, 3'd4);
		prog[2] = encodeInstr(1'b0, ulaPkg::OpSub, 3'd5, 3'd3, 3'd1);
		prog[3] = encodeInstr(1'b0, ulaPkg::OpShl, 3'd6, 3'd5, 3'd0);
		prog[4] = encodeInstr(1'b1, ulaPkg::OpAnd, 3'd7, 3'd6, 3'd0);  // Halt here
		for (int r = 0; r < ulaPkg::RegCount; r++)
			writeReg(ulaPkg::regAddrT'(r), randWord());
		for (int i = 0; i < 5; i++)
			writeProg(ulaPkg::pcT'(i), prog[i]);
		runProgram(5, 1'b1);
		for (int i = 0; i < 5; i++) begin
			a = expRegs[prog[i][6:4]];
			b = expRegs[prog[i][3:1]];
			expFlags = modelFlags(prog[i][14:10], a, b, expFlags);
			expRegs[prog[i][9:7]] = modelResult(prog[i][14:10], a, b);
		end
		checkFlags(prog[4][14:10]);
		for (int r = 0; r < ulaPkg::RegCount; r++)
			checkReg(ulaPkg::regAddrT'(r));
	endtask

	initial begin
		int unsigned seedInit;
		ulaPkg::opCodeT op;
		ulaPkg::wordT a;
		seedInit = $urandom(32'h70254d55);
		rstN <= 1'b0;
		progWe <= 1'b0;
		progAddr <= '0;
		progData <= '0;
		regWe <= 1'b0;
		regWrAddr <= '0;
		regWrData <= '0;
		regRdAddr <= '0;
		start <= 1'b0;
		expRegs = '{default: '0};
		expFlags = '0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		assert (!busy && !done && flags == 4'b0000) else
			failRun($sformatf("Fail %0t: status not clear after reset", $time));
		for (int r = 0; r < ulaPkg::RegCount; r++)
			checkReg(ulaPkg::regAddrT'(r));
		foreach (arithOps[i]) begin
			foreach (edgeVals[j]) begin
				foreach (edgeVals[k])
					checkOp(arithOps[i], edgeVals[j], edgeVals[k]);
			end
			repeat (2) checkOp(arithOps[i], randWord(), randWord());
		end
		checkOp(ulaPkg::OpAdd, 16'h7FFF, 16'h0001);  // Overflow set, shifts must keep it
		foreach (shiftOps[i]) begin
			foreach (edgeVals[j])
				checkOp(shiftOps[i], edgeVals[j], randWord());
			repeat (2) checkOp(shiftOps[i], randWord(), randWord());
		end
		checkOp(ulaPkg::OpShl, 16'hC001, 16'h0000);  // Carry and sign set, zero clear
		for (int c = 0; c < 32; c++) begin
			op = ulaPkg::opCodeT'(c);
			if (!(op inside {ulaPkg::OpAdd, ulaPkg::OpAddInc, ulaPkg::OpInc, ulaPkg::OpSubDec,
					ulaPkg::OpSub, ulaPkg::OpDec, ulaPkg::OpShl, ulaPkg::OpSar})) begin
				checkOp(op, randWord(), randWord());
				a = randWord();
				checkOp(op, a, a);  // Equal operands reach zero for xor and friends
			end
		end
		checkProgram();
		$display("NO ERRORS");
		$finish;
	end
endmodule

//--- build.f
+incdir+.
ulaPkg.sv
ulaBus.sv
ula.sv
regFile.sv
progMem.sv
pcCounter.sv
seqControl.sv
procUnit.sv
procUnitTb.sv

//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module procUnitTb \
		-f build.f -o procUnitSim \
	&& ./obj_dir/procUnitSim \
	|| exit 1
